/* src/lg_pkg.sv */
/*
  shared definitions for the logic pattern generator
  pattern width, bus register map and the config and payload structs
  import with lg_pkg::* in the module header
*/

package lg_pkg;

  //////////////////////////////////////////////////////////////////////
  // pattern and pin payloads
  //////////////////////////////////////////////////////////////////////

  localparam int lg_dw = 8;  // pattern width, one bit per pin

  typedef logic [lg_dw-1:0] lg_pat_t;  // one table entry / one beat

  typedef struct packed {
    lg_pat_t o;  // pin value
    lg_pat_t e;  // pin enable, 1 drives the pin
  } lg_pin_t;

  //////////////////////////////////////////////////////////////////////
  // configuration
  //////////////////////////////////////////////////////////////////////

  // all counts are stored minus one
  typedef struct packed {
    logic [13:0] bdr;  // repeats per entry
    logic [13:0] bdl;  // entries per burst
    logic [31:0] bpl;  // beats per period
    logic [15:0] bpn;  // periods per burst
    logic        inf;  // ignore bpn, run until stop
  } lg_burst_cfg_t;

  // output mask stage, all per bit
  typedef struct packed {
    lg_pat_t oen0;  // enable when value is 0
    lg_pat_t oen1;  // enable when value is 1
    lg_pat_t mode;  // 1 forces fixed value
    lg_pat_t val;   // fixed value / polarity
  } lg_out_cfg_t;

  //////////////////////////////////////////////////////////////////////
  // register offsets, low 7 address bits
  //////////////////////////////////////////////////////////////////////

  localparam logic [6:0] lg_reg_ctl  = 7'h00;  // w: b0 start b1 stop, r: b0 running
  localparam logic [6:0] lg_reg_trg  = 7'h08;  // trigger mask, b31 repeat enable
  localparam logic [6:0] lg_reg_bdr  = 7'h20;
  localparam logic [6:0] lg_reg_bdl  = 7'h24;
  localparam logic [6:0] lg_reg_bpl  = 7'h28;
  localparam logic [6:0] lg_reg_bpn  = 7'h2c;  // b31 infinite
  localparam logic [6:0] lg_reg_oen0 = 7'h40;
  localparam logic [6:0] lg_reg_oen1 = 7'h44;
  localparam logic [6:0] lg_reg_mode = 7'h48;
  localparam logic [6:0] lg_reg_val  = 7'h4c;

endpackage

/* src/lg_stream_if.sv */
/*
  valid/ready stream with a typed payload
  a beat moves on an edge with valid and ready both high
  source keeps data and last steady while stalled
*/

`timescale 1ns/1ps

interface lg_stream_if #(
  parameter type payload_t = logic
);

  logic     valid;  // source has a beat
  logic     ready;  // sink takes it
  payload_t data;
  logic     last;   // final beat of a period

  modport src (
    output valid, data, last,
    input  ready
  );

  modport snk (
    input  valid, data, last,
    output ready
  );

endinterface

/* src/lg_regs.sv */
/*
  bus register block of the pattern generator
  decodes config writes and reads, forwards table window writes
  combines masked triggers and software start into one start pulse
*/

`timescale 1ns/1ps

module lg_regs import lg_pkg::*; #(
  parameter int tn  = 4,  // trigger inputs
  parameter int taw = 6   // table address width
) (
  input  logic           bus,
  input  logic           reset,
  // simple bus
  input  logic [8:0]     addr,
  input  logic           wen,
  input  logic           ren,
  input  logic [31:0]    wdata,
  output logic [31:0]    rdata,
  output logic           ack,
  // triggers and status
  input  logic [tn-1:0]  trg,
  input  logic           running,
  // to sequencer and pin driver
  output lg_burst_cfg_t  burst_cfg,
  output lg_out_cfg_t    out_cfg,
  output logic           start,
  output logic           stop,
  output logic           tre,
  output logic           tbl_we,
  output logic [taw-1:0] tbl_addr,
  output lg_pat_t        tbl_wdata
);

  logic          reg_wr;    // write to register window
  logic          ctl_wr;    // write to control
  logic [tn-1:0] trg_mask;
  logic [31:0]   trg_word;  // mask zero extended

  assign reg_wr   = wen & ~addr[8];
  assign ctl_wr   = reg_wr & (addr[6:0] == lg_reg_ctl);
  assign trg_word = 32'(trg_mask);

  //////////////////////////////////////////////////////////////////////
  // bus handshake and config writes
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (reset) begin
      ack       <= 1'b0;
      trg_mask  <= '0;
      tre       <= 1'b0;
      burst_cfg <= '0;
      out_cfg   <= '0;
    end else begin
      ack <= wen | ren;  // one cycle after the request
      if (reg_wr) begin
        case (addr[6:0])
          lg_reg_trg: begin
            trg_mask <= wdata[tn-1:0];
            tre      <= wdata[31];
          end
          lg_reg_bdr:  burst_cfg.bdr <= wdata[13:0];
          lg_reg_bdl:  burst_cfg.bdl <= wdata[13:0];
          lg_reg_bpl:  burst_cfg.bpl <= wdata;
          lg_reg_bpn: begin
            burst_cfg.bpn <= wdata[15:0];
            burst_cfg.inf <= wdata[31];
          end
          lg_reg_oen0: out_cfg.oen0 <= wdata[lg_dw-1:0];
          lg_reg_oen1: out_cfg.oen1 <= wdata[lg_dw-1:0];
          lg_reg_mode: out_cfg.mode <= wdata[lg_dw-1:0];
          lg_reg_val:  out_cfg.val  <= wdata[lg_dw-1:0];
          default: ;  // ctl is events only
        endcase
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // events: start from trigger or software, stop from software
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (reset) begin
      start  <= 1'b0;
      stop   <= 1'b0;
      tbl_we <= 1'b0;
    end else begin
      start  <= |(trg & trg_mask) | (ctl_wr & wdata[0]);
      stop   <= ctl_wr & wdata[1];
      tbl_we <= wen & addr[8];  // table lands one edge later
    end
  end

  // table address and data follow tbl_we
  always_ff @(posedge bus) begin
    if (wen & addr[8]) begin
      tbl_addr  <= addr[taw+1:2];  // word address
      tbl_wdata <= wdata[lg_dw-1:0];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // readback, valid together with ack
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (ren) begin
      rdata <= '0;  // table window and holes read zero
      if (~addr[8]) begin
        case (addr[6:0])
          lg_reg_ctl:  rdata <= {31'd0, running};
          lg_reg_trg:  rdata <= {tre, trg_word[30:0]};
          lg_reg_bdr:  rdata <= {18'd0, burst_cfg.bdr};
          lg_reg_bdl:  rdata <= {18'd0, burst_cfg.bdl};
          lg_reg_bpl:  rdata <= burst_cfg.bpl;
          lg_reg_bpn:  rdata <= {burst_cfg.inf, 15'd0, burst_cfg.bpn};
          lg_reg_oen0: rdata <= 32'(out_cfg.oen0);
          lg_reg_oen1: rdata <= 32'(out_cfg.oen1);
          lg_reg_mode: rdata <= 32'(out_cfg.mode);
          lg_reg_val:  rdata <= 32'(out_cfg.val);
          default: ;
        endcase
      end
    end
  end

endmodule

/* src/lg_sequencer.sv */
/*
  burst sequencer with the pattern table
  walks entries with repeats, pads each period with the last entry
  one table read in flight ahead of the output beat
*/

`timescale 1ns/1ps

module lg_sequencer import lg_pkg::*; #(
  parameter int taw = 6  // table address width
) (
  input  logic           bus,
  input  logic           reset,
  input  lg_burst_cfg_t  burst_cfg,
  input  logic           start,
  input  logic           stop,
  input  logic           tre,        // restart while running
  input  logic           tbl_we,
  input  logic [taw-1:0] tbl_addr,
  input  lg_pat_t        tbl_wdata,
  output logic           running,
  output logic           tro,        // period start accepted
  output logic           irq,        // burst end accepted
  lg_stream_if.src       pat_s
);

  lg_pat_t     tbl [2**taw];  // pattern table
  lg_pat_t     rd_data;       // registered table read

  logic [13:0] cnt_rep;       // repeats of current entry
  logic [13:0] cnt_ent;       // entry index
  logic [31:0] cnt_bpl;       // beat within period
  logic [15:0] cnt_bpn;       // period index
  logic        iss_done;      // all beats of the burst issued

  logic        p_vld, p_last, p_first, p_end;  // read in flight
  logic        o_first, o_end;                 // flags of output beat

  logic        go, acc, p_move, issue;
  logic        b_last, b_end;

  //////////////////////////////////////////////////////////////////////
  // table
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (tbl_we) tbl[tbl_addr] <= tbl_wdata;
    if (issue)  rd_data <= tbl[cnt_ent[taw-1:0]];  // held until next issue
  end

  //////////////////////////////////////////////////////////////////////
  // flow control
  //////////////////////////////////////////////////////////////////////

  assign go     = start & (~running | tre);     // idle test lives here
  assign acc    = pat_s.valid & pat_s.ready;
  assign p_move = p_vld & (~pat_s.valid | pat_s.ready);
  assign issue  = running & ~iss_done & (~p_vld | p_move);

  // flags of the beat being issued
  assign b_last = (cnt_bpl == burst_cfg.bpl);
  assign b_end  = b_last & (cnt_bpn == burst_cfg.bpn) & ~burst_cfg.inf;

  always_ff @(posedge bus) begin
    if (reset) begin
      running     <= 1'b0;
      iss_done    <= 1'b0;
      cnt_rep     <= '0;
      cnt_ent     <= '0;
      cnt_bpl     <= '0;
      cnt_bpn     <= '0;
      p_vld       <= 1'b0;
      pat_s.valid <= 1'b0;
      tro         <= 1'b0;
      irq         <= 1'b0;
    end else begin
      tro <= acc & o_first;
      irq <= acc & o_end;
      if (stop) begin
        running     <= 1'b0;  // abort, drop everything in flight
        p_vld       <= 1'b0;
        pat_s.valid <= 1'b0;
      end else if (go) begin
        running     <= 1'b1;
        iss_done    <= 1'b0;
        cnt_rep     <= '0;
        cnt_ent     <= '0;
        cnt_bpl     <= '0;
        cnt_bpn     <= '0;
        p_vld       <= 1'b0;  // restart from entry 0
        pat_s.valid <= 1'b0;
      end else begin
        // output register
        if (p_move)   pat_s.valid <= 1'b1;
        else if (acc) pat_s.valid <= 1'b0;
        if (acc & o_end) running <= 1'b0;  // final beat taken
        // read stage
        if (issue)       p_vld <= 1'b1;
        else if (p_move) p_vld <= 1'b0;
        // burst counters step once per issued beat
        if (issue) begin
          if (b_last) begin
            cnt_bpl  <= '0;
            cnt_rep  <= '0;
            cnt_ent  <= '0;
            cnt_bpn  <= cnt_bpn + 16'd1;
            iss_done <= b_end;
          end else begin
            cnt_bpl <= cnt_bpl + 32'd1;
            if (cnt_rep == burst_cfg.bdr) begin
              cnt_rep <= '0;
              if (cnt_ent != burst_cfg.bdl) cnt_ent <= cnt_ent + 14'd1;  // else hold last
            end else begin
              cnt_rep <= cnt_rep + 14'd1;
            end
          end
        end
      end
    end
  end

  // payload and flags, no reset
  always_ff @(posedge bus) begin
    if (issue) begin
      p_last  <= b_last;
      p_first <= (cnt_bpl == 32'd0);
      p_end   <= b_end;
    end
    if (p_move) begin
      pat_s.data <= rd_data;
      pat_s.last <= p_last;
      o_first    <= p_first;
      o_end      <= p_end;
    end
  end

endmodule

/* src/lg_pin_driver.sv */
/*
  output mask stage, one register between pattern and pins
  per bit picks table data or fixed value, applies polarity
  enable comes from oen0 or oen1 by the resulting value
*/

`timescale 1ns/1ps

module lg_pin_driver import lg_pkg::*; (
  input  logic        bus,
  input  logic        reset,
  input  lg_out_cfg_t out_cfg,
  lg_stream_if.snk    pat_s,  // patterns in
  lg_stream_if.src    pin_s   // pin value and enable out
);

  lg_pat_t pin_val;  // value after mode and polarity
  lg_pin_t pin;      // masked beat before the register
  logic    acc;

  //////////////////////////////////////////////////////////////////////
  // masking, per bit
  //////////////////////////////////////////////////////////////////////

  assign pin_val = out_cfg.val ^ (~out_cfg.mode & pat_s.data);  // mode 1 -> fixed
  assign pin.o   = pin_val;
  assign pin.e   = (out_cfg.oen0 & ~pin_val)
                 | (out_cfg.oen1 &  pin_val);

  //////////////////////////////////////////////////////////////////////
  // register stage
  //////////////////////////////////////////////////////////////////////

  assign pat_s.ready = pin_s.ready | ~pin_s.valid;  // empty or draining
  assign acc         = pat_s.valid & pat_s.ready;

  always_ff @(posedge bus) begin
    if (reset) begin
      pin_s.valid <= 1'b0;
    end else if (acc) begin
      pin_s.valid <= 1'b1;
    end else if (pin_s.ready) begin
      pin_s.valid <= 1'b0;  // taken, nothing new
    end
  end

  always_ff @(posedge bus) begin
    if (acc) begin
      pin_s.data <= pin;
      pin_s.last <= pat_s.last;
    end
  end

endmodule

/* src/lg_top.sv */
/*
  top level of the logic pattern generator
  bus registers, burst sequencer and pin driver, pins as a plain stream
*/

`timescale 1ns/1ps

module lg_top import lg_pkg::*; #(
  parameter int tn  = 4,  // trigger inputs
  parameter int taw = 6   // table address width
) (
  input  logic          bus,
  input  logic          reset,
  // simple bus, addr[8] selects the table
  input  logic [8:0]    addr,
  input  logic          wen,
  input  logic          ren,
  input  logic [31:0]   wdata,
  output logic [31:0]   rdata,
  output logic          ack,
  // triggers, events
  input  logic [tn-1:0] trg,
  output logic          tro,
  output logic          irq,
  // pin stream
  output lg_pat_t       pin_o,
  output lg_pat_t       pin_e,
  output logic          pin_valid,
  output logic          pin_last,
  input  logic          pin_ready
);

  lg_burst_cfg_t  burst_cfg;
  lg_out_cfg_t    out_cfg;
  logic           start, stop, tre, running;
  logic           tbl_we;
  logic [taw-1:0] tbl_addr;
  lg_pat_t        tbl_wdata;

  lg_stream_if #(.payload_t(lg_pat_t)) pat_s ();  // sequencer -> pin driver
  lg_stream_if #(.payload_t(lg_pin_t)) pin_s ();  // pin driver -> ports

  //////////////////////////////////////////////////////////////////////
  // blocks
  //////////////////////////////////////////////////////////////////////

  lg_regs #(.tn(tn), .taw(taw)) u_regs (
    .bus, .reset,
    .addr, .wen, .ren, .wdata, .rdata, .ack,
    .trg, .running,
    .burst_cfg, .out_cfg,
    .start, .stop, .tre,
    .tbl_we, .tbl_addr, .tbl_wdata
  );

  lg_sequencer #(.taw(taw)) u_sequencer (
    .bus, .reset,
    .burst_cfg, .start, .stop, .tre,
    .tbl_we, .tbl_addr, .tbl_wdata,
    .running, .tro, .irq,
    .pat_s (pat_s.src)
  );

  lg_pin_driver u_pin_driver (
    .bus, .reset, .out_cfg,
    .pat_s (pat_s.snk),
    .pin_s (pin_s.src)
  );

  // pin stream out to plain ports
  assign pin_o       = pin_s.data.o;
  assign pin_e       = pin_s.data.e;
  assign pin_valid   = pin_s.valid;
  assign pin_last    = pin_s.last;
  assign pin_s.ready = pin_ready;

endmodule

/* test/lg_tb.sv */
/*
  directed testbench for the logic pattern generator
  bus model, beat monitor on the pin stream and a reference model
  of the burst and masking rules, one task per behavior
*/

`timescale 1ns/1ps

module lg_tb import lg_pkg::*; ();

  localparam int beats_total = 24 + 24 + 16 + 72 + 48;  // all tests together
  localparam int cycle_limit = beats_total * 4 + 2000;

  // readback test: offset, written word, expected word
  localparam logic [6:0] reg_ofs [9] = '{lg_reg_trg, lg_reg_bdr, lg_reg_bdl, lg_reg_bpl,
    lg_reg_bpn, lg_reg_oen0, lg_reg_oen1, lg_reg_mode, lg_reg_val};
  localparam logic [31:0] reg_wr [9] = '{32'h8000_00fa, 32'hffff_3a5c, 32'h0000_1234,
    32'hdead_beef, 32'hffff_4321, 32'h0000_01a5, 32'h0000_015a, 32'h0000_fff0, 32'h0000_0c3f};
  localparam logic [31:0] reg_rd [9] = '{32'h8000_000a, 32'h0000_3a5c, 32'h0000_1234,
    32'hdead_beef, 32'h8000_4321, 32'h0000_00a5, 32'h0000_005a, 32'h0000_00f0, 32'h0000_003f};

  logic          bus = 1'b0;
  logic          reset;
  logic [8:0]    addr;
  logic          wen, ren;
  logic [31:0]   wdata, rdata;
  logic          ack;
  logic [3:0]    trg;
  logic          tro, irq;
  lg_pat_t       pin_o, pin_e;
  logic          pin_valid, pin_last;
  logic          pin_ready = 1'b1;
  logic          rnd_ready = 1'b0;  // random back-pressure on

  int            cycles, errors, checks, tests;
  int            tro_cnt, irq_cnt;           // running totals, monitor only
  int            rx0, tro0, irq0;            // totals at start of a burst
  lg_pin_t       rx_pin[$], exp_pin[$];
  logic          rx_last[$], exp_last[$];
  lg_pat_t       tbl_model[64];              // what was loaded into the table
  lg_burst_cfg_t bcfg;                       // burst config as written
  lg_out_cfg_t   ocfg;                       // output config as written

  lg_top #(.tn(4), .taw(6)) u_lg_top (
    .bus, .reset, .addr, .wen, .ren, .wdata, .rdata, .ack, .trg, .tro, .irq,
    .pin_o, .pin_e, .pin_valid, .pin_last, .pin_ready
  );

  always #2 bus = ~bus;  // 4 ns period

  //////////////////////////////////////////////////////////////////////
  // background processes
  //////////////////////////////////////////////////////////////////////

  always @(posedge bus) begin
    cycles <= cycles + 1;
    if (cycles == cycle_limit) begin
      $display("timeout after %0d cycles, expected beats never arrived", cycle_limit);
      $display("TB FAILED");
      $finish;
    end
  end

  always begin
    @(posedge bus);
    #1;
    pin_ready = rnd_ready ? 1'($urandom % 2) : 1'b1;
  end

  // mid cycle, inputs and outputs both settled
  always @(negedge bus) begin
    if (pin_valid === 1'b1 && pin_ready === 1'b1) begin
      rx_pin.push_back({pin_o, pin_e});
      rx_last.push_back(pin_last);
    end
    if (tro === 1'b1) tro_cnt++;
    if (irq === 1'b1) irq_cnt++;
  end

  //////////////////////////////////////////////////////////////////////
  // bus model and helpers
  //////////////////////////////////////////////////////////////////////

  task automatic tick();
    @(posedge bus);
    #1;
  endtask

  task automatic bus_write(input logic [8:0] a, input logic [31:0] d);
    addr  = a;
    wdata = d;
    wen   = 1'b1;
    tick();
    wen = 1'b0;
    while (ack !== 1'b1) tick();
  endtask

  task automatic bus_read(input logic [8:0] a, output logic [31:0] d);
    addr = a;
    ren  = 1'b1;
    tick();
    ren = 1'b0;
    while (ack !== 1'b1) tick();
    d = rdata;  // valid with ack
  endtask

  function automatic int rx_count();
    return rx_pin.size() - rx0;
  endfunction

  task automatic mark_start();
    rx0  = rx_pin.size();
    tro0 = tro_cnt;
    irq0 = irq_cnt;
  endtask

  task automatic wait_beats(input int n);
    while (rx_count() < n) tick();
  endtask

  task automatic pulse_trigger(input int n);
    trg[n] = 1'b1;
    tick();
    trg = '0;
  endtask

  task automatic load_table();
    for (int i = 0; i < 64; i++) begin
      tbl_model[i] = lg_pat_t'(i * 29) ^ 8'h5a;  // every address bit matters
      bus_write(9'h100 | 9'(i * 4), 32'(tbl_model[i]));
    end
  endtask

  task automatic set_burst(input int bdr, bdl, bpl, bpn, input logic inf);
    bcfg = '{bdr: 14'(bdr), bdl: 14'(bdl), bpl: 32'(bpl), bpn: 16'(bpn), inf: inf};
    bus_write({2'b00, lg_reg_bdr}, 32'(bdr));
    bus_write({2'b00, lg_reg_bdl}, 32'(bdl));
    bus_write({2'b00, lg_reg_bpl}, 32'(bpl));
    bus_write({2'b00, lg_reg_bpn}, {inf, 15'd0, 16'(bpn)});
  endtask

  task automatic set_out(input lg_pat_t oen0, oen1, mode, val);
    ocfg = '{oen0: oen0, oen1: oen1, mode: mode, val: val};
    bus_write({2'b00, lg_reg_oen0}, 32'(oen0));
    bus_write({2'b00, lg_reg_oen1}, 32'(oen1));
    bus_write({2'b00, lg_reg_mode}, 32'(mode));
    bus_write({2'b00, lg_reg_val}, 32'(val));
  endtask

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  // pin by pin: mode set takes zero instead of data, val flips it
  function automatic lg_pin_t mask_pin(input lg_pat_t d);
    lg_pin_t p;
    for (int i = 0; i < lg_dw; i++) begin
      p.o[i] = ocfg.val[i] ^ (ocfg.mode[i] ? 1'b0 : d[i]);
      p.e[i] = p.o[i] ? ocfg.oen1[i] : ocfg.oen0[i];  // enable picked by value
    end
    return p;
  endfunction

  // entries with repeats, then the last entry held to the period end
  task automatic model_burst(input int periods);
    int ent;
    exp_pin.delete();
    exp_last.delete();
    for (int p = 0; p < periods; p++) begin
      for (int b = 0; b <= int'(bcfg.bpl); b++) begin
        ent = b / (int'(bcfg.bdr) + 1);
        if (ent > int'(bcfg.bdl)) ent = int'(bcfg.bdl);
        exp_pin.push_back(mask_pin(tbl_model[ent]));
        exp_last.push_back(b == int'(bcfg.bpl));
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic check_word(input string what, input logic [31:0] got, exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_pin(input int idx, input lg_pin_t got, input logic got_last,
                           input lg_pin_t exp, input logic exp_last);
    checks++;
    if (got !== exp || got_last !== exp_last) begin
      errors++;
      $display("Mismatch at %0t: pin beat %0d got o=%h e=%h last=%b expected o=%h e=%h last=%b",
               $time, idx, got.o, got.e, got_last, exp.o, exp.e, exp_last);
    end
  endtask

  task automatic check_pulse_count(input string what, input int got, exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("Mismatch at %0t: %s count got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  // received beats from 'from' against model beats from 'exp_from'
  task automatic compare_beats(input int from, exp_from, count);
    for (int i = 0; i < count && from + i < rx_count() && exp_from + i < exp_pin.size(); i++)
      check_pin(from + i, rx_pin[rx0 + from + i], rx_last[rx0 + from + i],
                exp_pin[exp_from + i], exp_last[exp_from + i]);
  endtask

  task automatic test_summary(input string name, input int e0);
    tests++;
    $display("test %-16s %s", name, (errors == e0) ? "ok" : "failed");
  endtask

  // one finite burst, waits for the end and checks everything
  task automatic finish_burst(input int beats, input int periods);
    logic [31:0] d;
    wait_beats(beats);
    while (irq_cnt == irq0) tick();
    bus_read({2'b00, lg_reg_ctl}, d);
    check_word("running", d, 32'd0);
    check_pulse_count("beat", rx_count(), beats);
    check_pulse_count("tro", tro_cnt - tro0, periods);
    check_pulse_count("irq", irq_cnt - irq0, 1);
    compare_beats(0, 0, beats);
  endtask

  //////////////////////////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////////////////////////

  task automatic regs_readback();
    int          e0;
    logic [31:0] d;
    e0 = errors;
    for (int i = 0; i < 9; i++) bus_write({2'b00, reg_ofs[i]}, reg_wr[i]);
    for (int i = 0; i < 9; i++) begin
      bus_read({2'b00, reg_ofs[i]}, d);
      check_word($sformatf("reg %h", reg_ofs[i]), d, reg_rd[i]);
    end
    bus_read({2'b00, lg_reg_ctl}, d);
    check_word("running", d, 32'd0);
    test_summary("regs readback", e0);
  endtask

  task automatic single_burst(input string name, input logic rnd);
    int e0;
    e0 = errors;
    set_burst(1, 3, 11, 1, 1'b0);  // 4 entries x2, period 12, 2 periods
    set_out(8'hff, 8'hff, 8'h00, 8'h00);
    bus_write({2'b00, lg_reg_trg}, 32'd0);
    model_burst(2);
    rnd_ready = rnd;
    mark_start();
    bus_write({2'b00, lg_reg_ctl}, 32'd1);  // software start
    finish_burst(24, 2);
    rnd_ready = 1'b0;
    test_summary(name, e0);
  endtask

  task automatic masked_run(input lg_pat_t oen0, oen1, mode, val);
    set_out(oen0, oen1, mode, val);
    model_burst(1);
    mark_start();
    bus_write({2'b00, lg_reg_ctl}, 32'd1);
    finish_burst(8, 1);
  endtask

  task automatic output_masking();
    int e0;
    e0 = errors;
    set_burst(0, 7, 7, 0, 1'b0);  // 8 entries once each
    masked_run(8'h0f, 8'hf5, 8'hf0, 8'h3c);
    masked_run(8'haa, 8'h55, 8'h00, 8'hff);  // inverted data
    test_summary("output masking", e0);
  endtask

  task automatic trigger_start();
    int          e0, k;
    logic [31:0] d;
    e0 = errors;
    set_burst(1, 3, 11, 1, 1'b0);
    set_out(8'hff, 8'hff, 8'h00, 8'h00);
    model_burst(2);
    bus_write({2'b00, lg_reg_trg}, 32'h0000_000b);  // trg[2] masked off
    mark_start();
    pulse_trigger(2);
    repeat (20) tick();
    bus_read({2'b00, lg_reg_ctl}, d);
    check_word("running after masked trigger", d, 32'd0);
    check_pulse_count("beat", rx_count(), 0);
    pulse_trigger(0);
    wait_beats(5);
    pulse_trigger(1);  // ignored, no repeat enable
    finish_burst(24, 2);
    // restart from entry 0 with repeat enable
    bus_write({2'b00, lg_reg_trg}, 32'h8000_000b);
    mark_start();
    pulse_trigger(3);
    wait_beats(5);
    pulse_trigger(0);
    while (irq_cnt == irq0) tick();
    bus_read({2'b00, lg_reg_ctl}, d);
    check_word("running after restart", d, 32'd0);
    k = rx_count() - 24;  // beats of the aborted burst
    if (k < 1 || k > 23) begin
      errors++;
      $display("trigger with repeat enable did not restart the burst, %0d beats seen",
               rx_count());
    end else begin
      compare_beats(0, 0, k);
      compare_beats(k, 0, 24);
      check_pulse_count("tro", tro_cnt - tro0, 3 + int'(k > 12));
      check_pulse_count("irq", irq_cnt - irq0, 1);
    end
    test_summary("trigger start", e0);
  endtask

  task automatic infinite_stop();
    int          e0, n;
    logic [31:0] d;
    e0 = errors;
    set_burst(0, 3, 5, 1, 1'b1);  // period 6, bpn ignored
    set_out(8'hff, 8'hff, 8'h00, 8'h00);
    bus_write({2'b00, lg_reg_trg}, 32'd0);
    model_burst(8);
    mark_start();
    bus_write({2'b00, lg_reg_ctl}, 32'd1);
    wait_beats(24);  // four periods, past bpn
    bus_write({2'b00, lg_reg_ctl}, 32'd2);
    repeat (4) tick();  // let the pin register drain
    bus_read({2'b00, lg_reg_ctl}, d);
    check_word("running after stop", d, 32'd0);
    n = rx_count();
    repeat (20) tick();
    check_pulse_count("beat after stop", rx_count(), n);
    check_pulse_count("irq", irq_cnt - irq0, 0);
    check_pulse_count("tro", tro_cnt - tro0, (n + 5) / 6);
    if (n > exp_pin.size()) begin
      errors++;
      $display("stream ran on after stop, %0d beats seen", n);
    end
    compare_beats(0, 0, n);
    test_summary("infinite and stop", e0);
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(32'hc09c1b7e));
    reset = 1'b1;
    addr  = '0;
    wen   = 1'b0;
    ren   = 1'b0;
    wdata = '0;
    trg   = '0;
    repeat (8) @(posedge bus);
    #1;
    reset = 1'b0;
    regs_readback();
    load_table();
    single_burst("single burst", 1'b0);
    single_burst("back-pressure", 1'b1);
    output_masking();
    trigger_start();
    infinite_stop();
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) $display("TB PASSED");
    else $display("TB FAILED");
    $finish;
  end

endmodule

/* lg.f */
src/lg_pkg.sv
src/lg_stream_if.sv
src/lg_regs.sv
src/lg_sequencer.sv
src/lg_pin_driver.sv
src/lg_top.sv
test/lg_tb.sv

/* Makefile */
# Verilator build and run of the pattern generator testbench

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	verilator --binary --timing -j 0 --top-module lg_tb -f lg.f -o lg_sim
	@out="$$(./obj_dir/lg_sim)"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf obj_dir
